// ==== hw/uc_pkg.sv ====
// Shared definitions for the uncached request handler
// Widths and vector types for addresses, data and identifiers
// Core operation, memory command and atomic sub-command encodings
// Early decode outcome, SC return codes and execute FSM states
// Core and memory request/response structs
package uc_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 64;
    localparam int LINE_OFS_W  = 6;
    localparam int RSRV_WORD_W = 3;
    localparam int ID_W        = 4;

    typedef logic [ADDR_W-1:0]            addr_t;
    typedef logic [DATA_W-1:0]            data_t;
    typedef logic [DATA_W/8-1:0]          be_t;
    typedef logic [2:0]                   size_t;
    typedef logic [ID_W-1:0]              id_t;
    typedef logic [ADDR_W-LINE_OFS_W-1:0] nline_t;

    typedef enum logic [3:0] {
        OP_LD, OP_ST, OP_LR, OP_SC, OP_SWAP, OP_ADD, OP_AND,
        OP_OR, OP_XOR, OP_MAX, OP_MAXU, OP_MIN, OP_MINU
    } uc_op_e;

    typedef enum logic [1:0] {
        MEM_READ, MEM_WRITE, MEM_ATOMIC
    } mem_cmd_e;

    typedef enum logic [3:0] {
        AMO_LDEX, AMO_STEX, AMO_SWAP, AMO_ADD, AMO_CLR, AMO_SET,
        AMO_EOR, AMO_SMAX, AMO_UMAX, AMO_SMIN, AMO_UMIN
    } mem_amo_e;

    typedef enum logic [1:0] {
        OUT_MEM, OUT_ERR, OUT_SC_FAIL
    } dec_outcome_e;

    localparam logic SC_SUCCESS = 1'b0;
    localparam logic SC_FAILURE = 1'b1;

    typedef struct packed {
        uc_op_e op;
        addr_t  addr;
        size_t  size;
        data_t  data;
        be_t    be;
        logic   uc;
        id_t    sid;
        id_t    tid;
        logic   need_rsp;
    } core_req_t;

    typedef struct packed {
        data_t rdata;
        id_t   sid;
        id_t   tid;
        logic  error;
    } core_rsp_t;

    typedef struct packed {
        mem_cmd_e cmd;
        mem_amo_e amo;
        addr_t    addr;
        size_t    size;
        data_t    data;
        be_t      be;
    } mem_req_t;

    typedef struct packed {
        data_t rdata;
        logic  error;
        logic  is_atomic;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_WAIT_PENDING, ST_MEM_REQ, ST_MEM_WAIT_RSP, ST_CORE_RSP
    } uc_state_e;

endpackage

// ==== hw/uc_decode.sv ====
// Request decode for the uncached handler
// Registers the accepted core request and classifies it
// Flags accepted SC and matching atomics for the reservation unit
`timescale 1ns/100ps

module uc_decode (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 req_accept_i,
    input  uc_pkg::core_req_t    req_i,
    input  logic                 cfg_err_cacheable_amo_i,
    input  logic                 rsrv_hit_i,
    output uc_pkg::core_req_t    req_q_o,
    output uc_pkg::dec_outcome_e outcome_o,
    output logic                 sc_accept_o,
    output logic                 amo_clear_o
);
    import uc_pkg::*;

    logic is_amo;
    logic is_sc;

    // LR and SC count as atomics here
    assign is_amo = (req_i.op != OP_LD) && (req_i.op != OP_ST);
    assign is_sc  = (req_i.op == OP_SC);

    // Outcome of the request on the input, used at acceptance
    always_comb begin
        if (is_amo && !req_i.uc && cfg_err_cacheable_amo_i) begin
            outcome_o = OUT_ERR;
        end else if (is_sc && !rsrv_hit_i) begin
            outcome_o = OUT_SC_FAIL;
        end else begin
            outcome_o = OUT_MEM;
        end
    end

    // Any SC drops the reservation, successful or not
    assign sc_accept_o = req_accept_i && is_sc;
    assign amo_clear_o = req_accept_i && is_amo && (req_i.op != OP_LR) && rsrv_hit_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q_o <= '0;
        end else if (req_accept_i) begin
            req_q_o <= req_i;
        end
    end

endmodule

// ==== hw/uc_lrsc_rsrv.sv ====
// LR/SC reservation for the uncached handler
// One 8-byte reservation, set by a completed LR
// Address match against the incoming request
// Invalidation on clear requests and covering write snoops
`timescale 1ns/100ps

module uc_lrsc_rsrv (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  uc_pkg::addr_t req_addr_i,
    input  logic          set_i,
    input  uc_pkg::addr_t set_addr_i,
    input  logic          clear_i,
    input  logic          snoop_valid_i,
    input  uc_pkg::addr_t snoop_addr_i,
    input  uc_pkg::size_t snoop_size_i,
    output logic          rsrv_hit_o
);
    import uc_pkg::*;

    logic                   rsrv_valid_q;
    addr_t                  rsrv_addr_q;
    nline_t                 rsrv_nline;
    logic [RSRV_WORD_W-1:0] rsrv_word;

    // Word counts need room for up to 16 words past index 7
    logic [7:0]             snoop_bytes;
    logic [4:0]             snoop_words;
    logic [4:0]             snoop_base;
    logic [4:0]             snoop_end;
    logic                   snoop_hit;

    assign rsrv_nline = rsrv_addr_q[LINE_OFS_W +: ADDR_W-LINE_OFS_W];
    assign rsrv_word  = rsrv_addr_q[3 +: RSRV_WORD_W];

    assign rsrv_hit_o = rsrv_valid_q &&
                        (rsrv_nline == req_addr_i[LINE_OFS_W +: ADDR_W-LINE_OFS_W]) &&
                        (rsrv_word  == req_addr_i[3 +: RSRV_WORD_W]);

    // Snoops narrower than a word still cover the whole word
    assign snoop_bytes = 8'h1 << snoop_size_i;
    assign snoop_words = (snoop_size_i < 3) ? 5'd1 : snoop_bytes[7:3];
    assign snoop_base  = {2'b00, snoop_addr_i[3 +: RSRV_WORD_W]};
    assign snoop_end   = snoop_base + snoop_words;

    assign snoop_hit = snoop_valid_i && rsrv_valid_q &&
                       (rsrv_nline == snoop_addr_i[LINE_OFS_W +: ADDR_W-LINE_OFS_W]) &&
                       ({2'b00, rsrv_word} >= snoop_base) &&
                       ({2'b00, rsrv_word} <  snoop_end);

    // A new LR wins over a same-cycle invalidation
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsrv_valid_q <= 1'b0;
        end else if (set_i) begin
            rsrv_valid_q <= 1'b1;
        end else if (clear_i || snoop_hit) begin
            rsrv_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (set_i) begin
            rsrv_addr_q <= set_addr_i;
        end
    end

endmodule

// ==== hw/uc_execute.sv ====
// Execute stage of the uncached handler
// Sequencing FSM: drain wait, memory request, response wait, core response
// Memory request formatting from the registered core request
// LR completion and failure pulses for the reservation unit
`timescale 1ns/100ps

module uc_execute (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    output logic                 req_accept_o,
    input  uc_pkg::core_req_t    req_q_i,
    input  uc_pkg::dec_outcome_e outcome_i,
    input  logic                 pending_empty_i,
    output logic                 mem_req_valid_o,
    input  logic                 mem_req_ready_i,
    output uc_pkg::mem_req_t     mem_req_o,
    input  logic                 mem_rsp_valid_i,
    input  logic                 mem_rsp_error_i,
    output logic                 lr_done_o,
    output logic                 lr_fail_o,
    output logic                 core_rsp_valid_o,
    input  logic                 core_rsp_ready_i
);
    import uc_pkg::*;

    uc_state_e state_q, state_d;
    logic      lr_rsp;

    assign req_ready_o      = (state_q == ST_IDLE);
    assign req_accept_o     = req_valid_i && req_ready_o;
    assign mem_req_valid_o  = (state_q == ST_MEM_REQ);
    assign core_rsp_valid_o = (state_q == ST_CORE_RSP);

    assign lr_rsp    = (state_q == ST_MEM_WAIT_RSP) && mem_rsp_valid_i && (req_q_i.op == OP_LR);
    assign lr_done_o = lr_rsp && !mem_rsp_error_i;
    assign lr_fail_o = lr_rsp && mem_rsp_error_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_accept_o) begin
                    // Errors and failed SCs skip memory entirely
                    if (outcome_i != OUT_MEM) begin
                        state_d = ST_CORE_RSP;
                    end else if (pending_empty_i) begin
                        state_d = ST_MEM_REQ;
                    end else begin
                        state_d = ST_WAIT_PENDING;
                    end
                end
            end
            ST_WAIT_PENDING: begin
                if (pending_empty_i) begin
                    state_d = ST_MEM_REQ;
                end
            end
            ST_MEM_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = ST_MEM_WAIT_RSP;
                end
            end
            ST_MEM_WAIT_RSP: begin
                if (mem_rsp_valid_i) begin
                    state_d = req_q_i.need_rsp ? ST_CORE_RSP : ST_IDLE;
                end
            end
            ST_CORE_RSP: begin
                if (core_rsp_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Command and sub-command per operation
    always_comb begin
        mem_req_o.cmd  = MEM_ATOMIC;
        mem_req_o.amo  = AMO_ADD;
        mem_req_o.addr = req_q_i.addr;
        mem_req_o.size = req_q_i.size;
        mem_req_o.data = req_q_i.data;
        mem_req_o.be   = req_q_i.be;
        case (req_q_i.op)
            OP_LD:   mem_req_o.cmd = MEM_READ;
            OP_ST:   mem_req_o.cmd = MEM_WRITE;
            OP_LR:   mem_req_o.amo = AMO_LDEX;
            OP_SC:   mem_req_o.amo = AMO_STEX;
            OP_SWAP: mem_req_o.amo = AMO_SWAP;
            OP_ADD:  mem_req_o.amo = AMO_ADD;
            OP_AND: begin
                // Memory only has bit clear, so send the cleared bits
                mem_req_o.amo  = AMO_CLR;
                mem_req_o.data = ~req_q_i.data;
            end
            OP_OR:   mem_req_o.amo = AMO_SET;
            OP_XOR:  mem_req_o.amo = AMO_EOR;
            OP_MAX:  mem_req_o.amo = AMO_SMAX;
            OP_MAXU: mem_req_o.amo = AMO_UMAX;
            OP_MIN:  mem_req_o.amo = AMO_SMIN;
            OP_MINU: mem_req_o.amo = AMO_UMIN;
            default: mem_req_o.cmd = MEM_READ;
        endcase
    end

endmodule

// ==== hw/uc_result.sv ====
// Response assembly for the uncached handler
// Captured memory read data, sticky error flag and SC return code
// Core response built from these and the registered request
`timescale 1ns/100ps

module uc_result (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 req_accept_i,
    input  uc_pkg::dec_outcome_e outcome_i,
    input  uc_pkg::core_req_t    req_q_i,
    input  logic                 mem_rsp_valid_i,
    input  uc_pkg::mem_rsp_t     mem_rsp_i,
    output uc_pkg::core_rsp_t    core_rsp_o
);
    import uc_pkg::*;

    data_t       rdata_q;
    logic        error_q;
    logic        sc_code_q;
    logic [31:0] sc_word;
    data_t       sc_rdata;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            error_q   <= 1'b0;
            sc_code_q <= SC_SUCCESS;
        end else if (req_accept_i) begin
            // A new request starts with a clean error flag
            error_q <= (outcome_i == OUT_ERR);
            if (outcome_i == OUT_SC_FAIL) begin
                sc_code_q <= SC_FAILURE;
            end
        end else if (mem_rsp_valid_i) begin
            if (mem_rsp_i.error && req_q_i.need_rsp) begin
                error_q <= 1'b1;
            end
            if (req_q_i.op == OP_SC) begin
                sc_code_q <= (mem_rsp_i.is_atomic && !mem_rsp_i.error) ?
                             SC_SUCCESS : SC_FAILURE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_rsp_valid_i) begin
            rdata_q <= mem_rsp_i.rdata;
        end
    end

    // 32-bit SC returns the code in both halves
    assign sc_word  = {31'd0, sc_code_q};
    assign sc_rdata = (req_q_i.size == size_t'(2)) ? {2{sc_word}} : {63'd0, sc_code_q};

    assign core_rsp_o.rdata = (req_q_i.op == OP_SC) ? sc_rdata : rdata_q;
    assign core_rsp_o.sid   = req_q_i.sid;
    assign core_rsp_o.tid   = req_q_i.tid;
    assign core_rsp_o.error = error_q;

endmodule

// ==== hw/uc_handler.sv ====
// Uncached request handler top level
// Connects request decode, LR/SC reservation, execute FSM
// and response assembly
`timescale 1ns/100ps

module uc_handler (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  uc_pkg::core_req_t req_i,
    output logic              core_rsp_valid_o,
    input  logic              core_rsp_ready_i,
    output uc_pkg::core_rsp_t core_rsp_o,
    output logic              mem_req_valid_o,
    input  logic              mem_req_ready_i,
    output uc_pkg::mem_req_t  mem_req_o,
    input  logic              mem_rsp_valid_i,
    input  uc_pkg::mem_rsp_t  mem_rsp_i,
    input  logic              pending_empty_i,
    input  logic              snoop_valid_i,
    input  uc_pkg::addr_t     snoop_addr_i,
    input  uc_pkg::size_t     snoop_size_i,
    input  logic              cfg_err_cacheable_amo_i
);
    import uc_pkg::*;

    logic         req_accept;
    core_req_t    req_q;
    dec_outcome_e outcome;
    logic         rsrv_hit;
    logic         sc_accept;
    logic         amo_clear;
    logic         lr_done;
    logic         lr_fail;
    logic         rsrv_clear;

    // Reservation is dropped by SC, conflicting atomics and failed LR
    assign rsrv_clear = sc_accept | amo_clear | lr_fail;

    uc_decode u_decode (
        .clk_i                   (clk_i),
        .rst_ni                  (rst_ni),
        .req_accept_i            (req_accept),
        .req_i                   (req_i),
        .cfg_err_cacheable_amo_i (cfg_err_cacheable_amo_i),
        .rsrv_hit_i              (rsrv_hit),
        .req_q_o                 (req_q),
        .outcome_o               (outcome),
        .sc_accept_o             (sc_accept),
        .amo_clear_o             (amo_clear)
    );

    uc_lrsc_rsrv u_lrsc_rsrv (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_addr_i    (req_i.addr),
        .set_i         (lr_done),
        .set_addr_i    (req_q.addr),
        .clear_i       (rsrv_clear),
        .snoop_valid_i (snoop_valid_i),
        .snoop_addr_i  (snoop_addr_i),
        .snoop_size_i  (snoop_size_i),
        .rsrv_hit_o    (rsrv_hit)
    );

    uc_execute u_execute (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .req_accept_o     (req_accept),
        .req_q_i          (req_q),
        .outcome_i        (outcome),
        .pending_empty_i  (pending_empty_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_o        (mem_req_o),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_error_i  (mem_rsp_i.error),
        .lr_done_o        (lr_done),
        .lr_fail_o        (lr_fail),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_ready_i (core_rsp_ready_i)
    );

    uc_result u_result (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_accept_i    (req_accept),
        .outcome_i       (outcome),
        .req_q_i         (req_q),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_i       (mem_rsp_i),
        .core_rsp_o      (core_rsp_o)
    );

endmodule

// ==== dv/uc_handler_assert.sv ====
// Protocol assertions for the uncached handler
// Request and response stability under back-pressure
// Memory response ordering and ready exclusion during a core response
`timescale 1ns/100ps

module uc_handler_assert (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              req_ready_o,
    input logic              core_rsp_valid_o,
    input logic              core_rsp_ready_i,
    input uc_pkg::core_rsp_t core_rsp_o,
    input logic              mem_req_valid_o,
    input logic              mem_req_ready_i,
    input uc_pkg::mem_req_t  mem_req_o,
    input logic              mem_rsp_valid_i
);
    logic outstanding_q;

    // Memory request sent, response not yet seen
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outstanding_q <= 1'b0;
        end else if (mem_req_valid_o && mem_req_ready_i) begin
            outstanding_q <= 1'b1;
        end else if (mem_rsp_valid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_valid_o && !mem_req_ready_i) |=> (mem_req_valid_o && $stable(mem_req_o)))
        else $error("memory request changed under back-pressure");

    core_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (core_rsp_valid_o && !core_rsp_ready_i) |=> (core_rsp_valid_o && $stable(core_rsp_o)))
        else $error("core response changed under back-pressure");

    mem_rsp_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rsp_valid_i |-> outstanding_q)
        else $error("memory response without an outstanding request");

    ready_during_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_valid_o |-> !req_ready_o)
        else $error("request ready while a core response is pending");

endmodule

bind uc_handler uc_handler_assert u_uc_handler_assert (.*);

// ==== dv/tb_uc_handler.sv ====
// Testbench for the uncached request handler
// Clock, reset, memory responder and core response sink
// Directed tests: load/store, errors, LR/SC, reservation loss, atomics, back-pressure
// Single compare task and a watchdog
`timescale 1ns/100ps

module tb_uc_handler;
    import uc_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RST_CYCLES     = 8;
    localparam int NUM_REQS       = 40;
    localparam int CYCLES_PER_REQ = 30;
    localparam int TIMEOUT_NS     = (RST_CYCLES + NUM_REQS * CYCLES_PER_REQ) * CLK_PERIOD;
    localparam addr_t LINE_A      = 32'h2000_0080;

    logic      clk_i;
    logic      rst_ni;
    logic      req_valid_i;
    logic      req_ready_o;
    core_req_t req_i;
    logic      core_rsp_valid_o;
    logic      core_rsp_ready_i;
    core_rsp_t core_rsp_o;
    logic      mem_req_valid_o;
    logic      mem_req_ready_i;
    mem_req_t  mem_req_o;
    logic      mem_rsp_valid_i;
    mem_rsp_t  mem_rsp_i;
    logic      pending_empty_i;
    logic      snoop_valid_i;
    addr_t     snoop_addr_i;
    size_t     snoop_size_i;
    logic      cfg_err_cacheable_amo_i;

    int        err_count;
    int        tag_cnt;
    core_req_t sent_req;
    mem_req_t  seen_req;
    core_rsp_t seen_rsp;

    uc_handler u_uc_handler (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic core_req_t make_req(input uc_op_e op, input addr_t addr,
                                           input size_t size, input data_t data,
                                           input logic uc, input logic need_rsp);
        core_req_t r;
        r          = '0;
        r.op       = op;
        r.addr     = addr;
        r.size     = size;
        r.data     = data;
        r.be       = '1;
        r.uc       = uc;
        r.need_rsp = need_rsp;
        return r;
    endfunction

    // Sub-command each atomic maps to on the memory side
    function automatic mem_amo_e expected_amo(input uc_op_e op);
        case (op)
            OP_LR:   return AMO_LDEX;
            OP_SC:   return AMO_STEX;
            OP_SWAP: return AMO_SWAP;
            OP_ADD:  return AMO_ADD;
            OP_AND:  return AMO_CLR;
            OP_OR:   return AMO_SET;
            OP_XOR:  return AMO_EOR;
            OP_MAX:  return AMO_SMAX;
            OP_MAXU: return AMO_UMAX;
            OP_MIN:  return AMO_SMIN;
            default: return AMO_UMIN;
        endcase
    endfunction

    // Size 2 repeats the 32-bit code in both halves
    function automatic data_t expected_sc(input logic code, input size_t size);
        if (size == 3'd2) begin
            return {31'd0, code, 31'd0, code};
        end
        return {63'd0, code};
    endfunction

    task automatic send_req(input core_req_t r);
        r.sid    = id_t'(tag_cnt);
        r.tid    = id_t'(tag_cnt * 3 + 1);
        tag_cnt++;
        sent_req = r;
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_i       <= r;
        @(negedge clk_i);
        while (!req_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        req_valid_i <= 1'b0;
    endtask

    // Holds ready low for hold cycles, answers delay cycles after the transfer
    task automatic serve_mem(input int hold, input int delay, input data_t rdata,
                             input logic error, input logic atomic);
        @(negedge clk_i);
        while (!mem_req_valid_o) begin
            @(negedge clk_i);
        end
        seen_req = mem_req_o;
        repeat (hold) begin
            @(negedge clk_i);
            check_value("mem_req_valid_o", 64'(mem_req_valid_o), 64'd1);
            check_value("mem_req_o.addr", 64'(mem_req_o.addr), 64'(seen_req.addr));
            check_value("mem_req_o.data", mem_req_o.data, seen_req.data);
        end
        @(posedge clk_i);
        mem_req_ready_i <= 1'b1;
        @(posedge clk_i);
        mem_req_ready_i <= 1'b0;
        repeat (delay) @(posedge clk_i);
        mem_rsp_valid_i     <= 1'b1;
        mem_rsp_i.rdata     <= rdata;
        mem_rsp_i.error     <= error;
        mem_rsp_i.is_atomic <= atomic;
        @(posedge clk_i);
        mem_rsp_valid_i <= 1'b0;
    endtask

    task automatic take_rsp(input int hold);
        @(negedge clk_i);
        while (!core_rsp_valid_o) begin
            @(negedge clk_i);
        end
        seen_rsp = core_rsp_o;
        repeat (hold) begin
            @(negedge clk_i);
            check_value("core_rsp_valid_o", 64'(core_rsp_valid_o), 64'd1);
            check_value("req_ready_o", 64'(req_ready_o), 64'd0);
            check_value("core_rsp_o.rdata", core_rsp_o.rdata, seen_rsp.rdata);
        end
        @(posedge clk_i);
        core_rsp_ready_i <= 1'b1;
        @(posedge clk_i);
        core_rsp_ready_i <= 1'b0;
        check_value("core_rsp_o.sid", 64'(seen_rsp.sid), 64'(sent_req.sid));
        check_value("core_rsp_o.tid", 64'(seen_rsp.tid), 64'(sent_req.tid));
    endtask

    // Early outcomes answer the cycle after acceptance without touching memory
    task automatic expect_direct_rsp();
        @(negedge clk_i);
        check_value("mem_req_valid_o", 64'(mem_req_valid_o), 64'd0);
        check_value("core_rsp_valid_o", 64'(core_rsp_valid_o), 64'd1);
    endtask

    task automatic snoop_write(input addr_t addr, input size_t size);
        @(posedge clk_i);
        snoop_valid_i <= 1'b1;
        snoop_addr_i  <= addr;
        snoop_size_i  <= size;
        @(posedge clk_i);
        snoop_valid_i <= 1'b0;
    endtask

    task automatic lr_to(input addr_t addr);
        send_req(make_req(OP_LR, addr, 3'd3, '0, 1'b1, 1'b1));
        serve_mem(0, 1, {$urandom, $urandom}, 1'b0, 1'b1);
        check_value("mem_req_o.cmd", 64'(seen_req.cmd), 64'(MEM_ATOMIC));
        check_value("mem_req_o.amo", 64'(seen_req.amo), 64'(AMO_LDEX));
        take_rsp(0);
    endtask

    task automatic sc_pass(input addr_t addr, input size_t size);
        send_req(make_req(OP_SC, addr, size, {$urandom, $urandom}, 1'b1, 1'b1));
        serve_mem(0, 2, '1, 1'b0, 1'b1);
        check_value("mem_req_o.amo", 64'(seen_req.amo), 64'(AMO_STEX));
        take_rsp(0);
        check_value("core_rsp_o.rdata", seen_rsp.rdata, expected_sc(SC_SUCCESS, size));
    endtask

    task automatic sc_fail(input addr_t addr, input size_t size);
        send_req(make_req(OP_SC, addr, size, {$urandom, $urandom}, 1'b1, 1'b1));
        expect_direct_rsp();
        take_rsp(0);
        check_value("core_rsp_o.rdata", seen_rsp.rdata, expected_sc(SC_FAILURE, size));
    endtask

    task automatic test_load_store();
        data_t     d;
        core_req_t st;
        d = {$urandom, $urandom};
        send_req(make_req(OP_LD, 32'h1000_0048, 3'd3, '0, 1'b1, 1'b1));
        serve_mem(0, 2, d, 1'b0, 1'b0);
        check_value("mem_req_o.cmd", 64'(seen_req.cmd), 64'(MEM_READ));
        check_value("mem_req_o.addr", 64'(seen_req.addr), 64'h1000_0048);
        check_value("mem_req_o.size", 64'(seen_req.size), 64'd3);
        take_rsp(0);
        check_value("core_rsp_o.rdata", seen_rsp.rdata, d);
        check_value("core_rsp_o.error", 64'(seen_rsp.error), 64'd0);
        // Store without need_rsp completes silently
        st    = make_req(OP_ST, 32'h1000_0050, 3'd2, ~d, 1'b1, 1'b0);
        st.be = 8'h0f;
        send_req(st);
        serve_mem(0, 1, '0, 1'b0, 1'b0);
        check_value("mem_req_o.cmd", 64'(seen_req.cmd), 64'(MEM_WRITE));
        check_value("mem_req_o.data", seen_req.data, ~d);
        check_value("mem_req_o.be", 64'(seen_req.be), 64'h0f);
        repeat (5) begin
            @(negedge clk_i);
            check_value("core_rsp_valid_o", 64'(core_rsp_valid_o), 64'd0);
        end
        check_value("req_ready_o", 64'(req_ready_o), 64'd1);
    endtask

    task automatic test_errors();
        send_req(make_req(OP_ST, 32'h1000_0100, 3'd3, 64'h5a5a, 1'b1, 1'b1));
        serve_mem(0, 1, '0, 1'b1, 1'b0);
        take_rsp(0);
        check_value("core_rsp_o.error", 64'(seen_rsp.error), 64'd1);
        @(posedge clk_i);
        cfg_err_cacheable_amo_i <= 1'b1;
        send_req(make_req(OP_ADD, 32'h1000_0108, 3'd3, 64'h1, 1'b0, 1'b1));
        expect_direct_rsp();
        take_rsp(0);
        check_value("core_rsp_o.error", 64'(seen_rsp.error), 64'd1);
        @(posedge clk_i);
        cfg_err_cacheable_amo_i <= 1'b0;
        send_req(make_req(OP_LD, 32'h1000_0110, 3'd3, '0, 1'b1, 1'b1));
        serve_mem(0, 1, 64'h77, 1'b0, 1'b0);
        take_rsp(0);
        check_value("core_rsp_o.error", 64'(seen_rsp.error), 64'd0);
    endtask

    task automatic test_lrsc();
        lr_to(LINE_A);
        sc_pass(LINE_A, 3'd3);
        lr_to(LINE_A);
        sc_pass(LINE_A + 32'h4, 3'd2);
        sc_fail(LINE_A, 3'd3);
        sc_fail(LINE_A, 3'd2);
    endtask

    task automatic test_rsrv_loss();
        lr_to(LINE_A);
        snoop_write(LINE_A, 3'd3);
        sc_fail(LINE_A, 3'd3);
        // 64-byte snoop from the line base covers word 5
        lr_to(LINE_A + 32'h28);
        snoop_write(LINE_A, 3'd6);
        sc_fail(LINE_A + 32'h28, 3'd3);
        lr_to(LINE_A);
        send_req(make_req(OP_SWAP, LINE_A, 3'd3, 64'h1234, 1'b1, 1'b1));
        serve_mem(0, 1, 64'h9, 1'b0, 1'b1);
        check_value("mem_req_o.amo", 64'(seen_req.amo), 64'(AMO_SWAP));
        take_rsp(0);
        sc_fail(LINE_A, 3'd3);
        lr_to(LINE_A);
        snoop_write(LINE_A + 32'h100, 3'd3);
        sc_pass(LINE_A, 3'd3);
    endtask

    task automatic test_amo_cmds();
        int     i;
        uc_op_e op;
        data_t  d;
        for (i = int'(OP_SWAP); i <= int'(OP_MINU); i++) begin
            op = uc_op_e'(i);
            d  = {$urandom, $urandom};
            send_req(make_req(op, 32'h3000_0000 + i * 8, 3'd3, d, 1'b1, 1'b1));
            serve_mem(0, 1, ~d, 1'b0, 1'b1);
            check_value("mem_req_o.cmd", 64'(seen_req.cmd), 64'(MEM_ATOMIC));
            check_value("mem_req_o.amo", 64'(seen_req.amo), 64'(expected_amo(op)));
            check_value("mem_req_o.data", seen_req.data, (op == OP_AND) ? ~d : d);
            take_rsp(0);
            check_value("core_rsp_o.rdata", seen_rsp.rdata, ~d);
        end
    endtask

    task automatic test_backpressure();
        data_t d;
        d = {$urandom, $urandom};
        @(posedge clk_i);
        pending_empty_i <= 1'b0;
        send_req(make_req(OP_LD, 32'h4000_0018, 3'd3, '0, 1'b1, 1'b1));
        repeat (6) begin
            @(negedge clk_i);
            check_value("mem_req_valid_o", 64'(mem_req_valid_o), 64'd0);
        end
        @(posedge clk_i);
        pending_empty_i <= 1'b1;
        serve_mem(4, 3, d, 1'b0, 1'b0);
        take_rsp(4);
        check_value("core_rsp_o.rdata", seen_rsp.rdata, d);
    endtask

    initial begin
        void'($urandom(32'h77e2cf79));
        err_count               = 0;
        tag_cnt                 = 1;
        rst_ni                  = 1'b0;
        req_valid_i             = 1'b0;
        req_i                   = '0;
        core_rsp_ready_i        = 1'b0;
        mem_req_ready_i         = 1'b0;
        mem_rsp_valid_i         = 1'b0;
        mem_rsp_i               = '0;
        pending_empty_i         = 1'b1;
        snoop_valid_i           = 1'b0;
        snoop_addr_i            = '0;
        snoop_size_i            = '0;
        cfg_err_cacheable_amo_i = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_value("req_ready_o", 64'(req_ready_o), 64'd1);
        check_value("mem_req_valid_o", 64'(mem_req_valid_o), 64'd0);
        check_value("core_rsp_valid_o", 64'(core_rsp_valid_o), 64'd0);
        test_load_store();
        test_errors();
        test_lrsc();
        test_rsrv_loss();
        test_amo_cmds();
        test_backpressure();
        repeat (3) @(posedge clk_i);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not complete within %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== files.f ====
hw/uc_pkg.sv
hw/uc_decode.sv
hw/uc_lrsc_rsrv.sv
hw/uc_execute.sv
hw/uc_result.sv
hw/uc_handler.sv
dv/uc_handler_assert.sv
dv/tb_uc_handler.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_uc_handler
FILELIST  := files.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := All checks passed
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
